// File: source/pool_pkg.sv
package pool_pkg;

	localparam int PIXEL_W = 22;
	localparam int RES_IDX_W = 8; // 256 results, a full 32x32 map.
	localparam int CH_W = 1;
	localparam int ADDR_W = CH_W + RES_IDX_W; // channel above index.

	typedef logic signed [PIXEL_W-1:0] pixel_t;

	// One pooled value with its place in the result memory.
	typedef struct packed {
		pixel_t value;
		logic [RES_IDX_W-1:0] index; // raster position in the pooled map.
		logic [CH_W-1:0] channel;
	} pool_result_t;

endpackage

// File: source/max_pool_2x2.sv
module max_pool_2x2 #(
	parameter int IMG_WIDTH = 32,
	parameter int IMG_HEIGHT = 32,
	parameter int CHANNEL = 0
) (
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input pool_pkg::pixel_t pixel_in,
	output pool_pkg::pool_result_t result,
	output logic result_valid,
	output logic done
);
	import pool_pkg::*;

	localparam int COL_W = $clog2(IMG_WIDTH);
	localparam int ROW_W = $clog2(IMG_HEIGHT);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PROC,
		ST_DONE
	} state_t;

	state_t state;
	state_t next_state;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic [RES_IDX_W-1:0] res_idx;
	pixel_t line_buf [IMG_WIDTH];
	pixel_t pixel_d1;
	pixel_t top_d1;
	pixel_t top_left;
	pixel_t top_right;
	pixel_t bot_left;
	pixel_t bot_right;
	pixel_t max_top;
	pixel_t max_bot;
	pixel_t win_max;
	logic accept;
	logic last_col;
	logic last_pixel;
	logic win_end;

	assign accept = pixel_valid && (state != ST_DONE);
	assign last_col = (col == COL_W'(IMG_WIDTH - 1));
	assign last_pixel = accept && last_col && (row == ROW_W'(IMG_HEIGHT - 1));
	assign win_end = accept && col[0] && row[0]; // bottom-right pixel of a window.

	// The line buffer still holds the previous row at col until this pixel overwrites it,
	// so top_d1 keeps that old value for the next column's top-left tap.
	always_ff @(posedge clk) begin
		if (accept) begin
			line_buf[col] <= pixel_in;
			pixel_d1 <= pixel_in;
			top_d1 <= line_buf[col];
		end
	end

	assign top_left = top_d1;
	assign top_right = line_buf[col];
	assign bot_left = pixel_d1;
	assign bot_right = pixel_in;

	assign max_top = (top_left >= top_right) ? top_left : top_right; // signed compare.
	assign max_bot = (bot_left >= bot_right) ? bot_left : bot_right;
	assign win_max = (max_top >= max_bot) ? max_top : max_bot;

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
			res_idx <= '0;
		end else if (accept) begin
			if (last_col) begin
				col <= '0;
				row <= (row == ROW_W'(IMG_HEIGHT - 1)) ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
			if (win_end) begin
				res_idx <= last_pixel ? '0 : res_idx + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (accept) begin
					next_state = ST_PROC;
				end
			end
			ST_PROC: begin
				if (last_pixel) begin
					next_state = ST_DONE;
				end
			end
			ST_DONE: next_state = ST_IDLE;
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			result_valid <= 1'b0;
		end else begin
			state <= next_state;
			result_valid <= win_end;
		end
	end

	always_ff @(posedge clk) begin
		if (win_end) begin
			result.value <= win_max;
			result.index <= res_idx;
			result.channel <= CH_W'(CHANNEL);
		end
	end

	assign done = (state == ST_DONE); // lines up with the last result.

	// the source must leave one idle cycle after the last pixel of a frame.
	assert property (@(posedge clk) disable iff (rst) (state == ST_DONE) |-> !pixel_valid)
		else $error("max_pool_2x2 ch%0d: pixel_valid in done state", CHANNEL);

endmodule

// File: source/pool_write_arbiter.sv
module pool_write_arbiter #(
	parameter int NUM_CHANNELS = 2
) (
	input logic clk,
	input logic rst,
	input pool_pkg::pool_result_t [NUM_CHANNELS-1:0] results,
	input logic [NUM_CHANNELS-1:0] result_valid,
	input logic [NUM_CHANNELS-1:0] done,
	output logic wr_en,
	output logic [pool_pkg::ADDR_W-1:0] wr_addr,
	output pool_pkg::pixel_t wr_data,
	output logic frame_done
);
	import pool_pkg::*;

	pool_result_t slot [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] slot_full;
	logic [NUM_CHANNELS-1:0] done_seen;
	logic [CH_W-1:0] last_ch;
	logic [CH_W-1:0] grant_ch;
	logic frame_ready;

	// round robin, searching from the channel after the last one served.
	always_comb begin
		int idx;
		wr_en = 1'b0;
		grant_ch = last_ch;
		for (int k = 1; k <= NUM_CHANNELS; k++) begin
			idx = (int'(last_ch) + k) % NUM_CHANNELS;
			if (!wr_en && slot_full[idx]) begin
				wr_en = 1'b1;
				grant_ch = CH_W'(idx);
			end
		end
	end

	assign wr_data = slot[grant_ch].value;
	assign wr_addr = {slot[grant_ch].channel, slot[grant_ch].index};

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			if (result_valid[i]) begin
				slot[i] <= results[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_full <= '0;
			last_ch <= CH_W'(NUM_CHANNELS - 1); // channel 0 goes first.
		end else begin
			for (int i = 0; i < NUM_CHANNELS; i++) begin
				if (result_valid[i]) begin
					slot_full[i] <= 1'b1; // a drain and a refill may share a cycle.
				end else if (wr_en && grant_ch == CH_W'(i)) begin
					slot_full[i] <= 1'b0;
				end
			end
			if (wr_en) begin
				last_ch <= grant_ch;
			end
		end
	end

	assign frame_ready = (&done_seen) && !(|slot_full);

	always_ff @(posedge clk) begin
		if (rst) begin
			done_seen <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= frame_ready;
			done_seen <= (frame_ready ? '0 : done_seen) | done;
		end
	end

	for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_slot_chk
		assert property (@(posedge clk) disable iff (rst)
			result_valid[g] |-> (!slot_full[g] || (wr_en && grant_ch == CH_W'(g))))
			else $error("pool_write_arbiter: result lost on channel %0d", g);
	end

	assert property (@(posedge clk) disable iff (rst) frame_done |-> !(|slot_full))
		else $error("pool_write_arbiter: frame_done with a result still pending");

endmodule

// File: source/pool_result_ram.sv
module pool_result_ram (
	input logic clk,
	input logic wr_en,
	input logic [pool_pkg::ADDR_W-1:0] wr_addr,
	input pool_pkg::pixel_t wr_data,
	input logic [pool_pkg::ADDR_W-1:0] rd_addr,
	output pool_pkg::pixel_t rd_data
);
	import pool_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W; // every channel gets its own half.

	pixel_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr]; // one cycle read latency.
	end

endmodule

// File: source/pooling_top.sv
module pooling_top #(
	parameter int IMG_WIDTH = 32,
	parameter int IMG_HEIGHT = 32,
	parameter int NUM_CHANNELS = 2
) (
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input pool_pkg::pixel_t [NUM_CHANNELS-1:0] pixels,
	input logic [pool_pkg::ADDR_W-1:0] rd_addr,
	output pool_pkg::pixel_t rd_data,
	output logic frame_done
);
	import pool_pkg::*;

	pool_result_t [NUM_CHANNELS-1:0] results;
	logic [NUM_CHANNELS-1:0] result_valid;
	logic [NUM_CHANNELS-1:0] done;
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	pixel_t wr_data;

	if ((IMG_WIDTH % 2) != 0 || (IMG_HEIGHT % 2) != 0 || IMG_WIDTH > 32 || IMG_HEIGHT > 32)
	begin : g_bad_size
		$error("pooling_top: image sides must be even and at most 32.");
	end

	if (NUM_CHANNELS < 1 || NUM_CHANNELS > 2 ** CH_W) begin : g_bad_chan
		$error("pooling_top: unsupported channel count.");
	end

	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
		max_pool_2x2 #(
			.IMG_WIDTH(IMG_WIDTH),
			.IMG_HEIGHT(IMG_HEIGHT),
			.CHANNEL(ch)
		) u_pool (
			.clk(clk),
			.rst(rst),
			.pixel_valid(pixel_valid), // all channels run in lockstep.
			.pixel_in(pixels[ch]),
			.result(results[ch]),
			.result_valid(result_valid[ch]),
			.done(done[ch])
		);
	end

	pool_write_arbiter #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_arbiter (
		.clk(clk),
		.rst(rst),
		.results(results),
		.result_valid(result_valid),
		.done(done),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.frame_done(frame_done)
	);

	pool_result_ram u_ram (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// File: sim/pooling_tb.sv
module pooling_tb;
	import pool_pkg::*;

	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int NUM_CH = 2;
	localparam int WIN_W = IMG_W / 2;
	localparam int WIN_H = IMG_H / 2;
	localparam int WINS = WIN_W * WIN_H; // results per channel and frame.
	localparam int FRAME_PIX = IMG_W * IMG_H * NUM_CH;
	localparam int N_FRAMES = 6;
	localparam int CYCLE_LIMIT = N_FRAMES * 2 * FRAME_PIX + 200;
	localparam logic [31:0] SEED = 32'ha09a_3665;

	typedef enum logic [2:0] {
		K_RAMP,
		K_DESC,
		K_NEG,
		K_PEAK,
		K_RAND,
		K_REPEAT // replays the last random image.
	} kind_t;

	typedef struct packed {
		kind_t kind0;
		kind_t kind1;
		logic [6:0] gap_pct; // chance of an idle cycle before each pixel.
	} frame_cfg_t;

	frame_cfg_t frame_table [N_FRAMES] = '{
		'{K_RAMP, K_DESC, 7'd0},
		'{K_RAND, K_RAND, 7'd0},
		'{K_NEG, K_PEAK, 7'd0},
		'{K_REPEAT, K_REPEAT, 7'd30},
		'{K_PEAK, K_NEG, 7'd20},
		'{K_DESC, K_RAMP, 7'd25}
	};
	string frame_name [N_FRAMES] = '{"ramp_desc", "random_solid", "neg_peak",
		"random_gaps", "peak_neg_gaps", "desc_ramp_gaps"};

	logic clk;
	logic rst;
	logic pixel_valid;
	pixel_t [NUM_CH-1:0] pixels;
	logic [ADDR_W-1:0] rd_addr;
	pixel_t rd_data;
	logic frame_done;

	pixel_t img [NUM_CH][IMG_H][IMG_W];
	pixel_t rand_img [NUM_CH][IMG_H][IMG_W];
	int error_count = 0;
	int check_count = 0;
	int done_count = 0;
	int cycle_count = 0;

	pooling_top #(
		.IMG_WIDTH(IMG_W),
		.IMG_HEIGHT(IMG_H),
		.NUM_CHANNELS(NUM_CH)
	) dut (
		.clk(clk),
		.rst(rst),
		.pixel_valid(pixel_valid),
		.pixels(pixels),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.frame_done(frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (frame_done === 1'b1) begin
			done_count <= done_count + 1; // counted on the edge that ends the pulse.
		end
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
		end
		$display("timeout: frame_done never arrived within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic check_value(input string name, input longint expected, input longint actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	function automatic pixel_t gen_pixel(kind_t kind, int ch, int r, int c);
		int pos;
		int wpos;
		pixel_t value;
		pos = r * IMG_W + c;
		wpos = ((r / 2) * WIN_W + (c / 2) + ch) % 4; // peak position moves from window to window.
		case (kind)
			K_RAMP: value = pixel_t'(pos + ch * 100);
			K_DESC: value = pixel_t'(5000 - pos * 3 - ch);
			K_NEG: value = pixel_t'(-1 - ((r * 13 + c * 29 + ch * 5) % 61) * 1000);
			K_PEAK: value = ((r % 2) * 2 + (c % 2) == wpos) ? pixel_t'(2000 + pos) : pixel_t'(-3);
			default: value = pixel_t'($urandom);
		endcase
		return value;
	endfunction

	// reference rule: the signed maximum of the four pixels of a window.
	function automatic pixel_t window_max(int ch, int wr, int wc);
		pixel_t best;
		best = img[ch][2 * wr][2 * wc];
		for (int dy = 0; dy < 2; dy++) begin
			for (int dx = 0; dx < 2; dx++) begin
				if (img[ch][2 * wr + dy][2 * wc + dx] > best) begin
					best = img[ch][2 * wr + dy][2 * wc + dx];
				end
			end
		end
		return best;
	endfunction

	function automatic logic [ADDR_W-1:0] addr_of(int n);
		int ch;
		int idx;
		ch = n / WINS;
		idx = n % WINS;
		return ADDR_W'((ch << RES_IDX_W) | idx);
	endfunction

	task automatic stream_frame(input int f);
		kind_t kind;
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				for (int ch = 0; ch < NUM_CH; ch++) begin
					kind = (ch == 0) ? frame_table[f].kind0 : frame_table[f].kind1;
					if (kind == K_REPEAT) begin
						img[ch][r][c] = rand_img[ch][r][c];
					end else begin
						img[ch][r][c] = gen_pixel(kind, ch, r, c);
					end
					if (kind == K_RAND) begin
						rand_img[ch][r][c] = img[ch][r][c];
					end
				end
				while (($urandom % 100) < 32'(frame_table[f].gap_pct)) begin
					@(posedge clk);
					pixel_valid <= 1'b0;
				end
				@(posedge clk);
				pixel_valid <= 1'b1;
				for (int ch = 0; ch < NUM_CH; ch++) begin
					pixels[ch] <= img[ch][r][c];
				end
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0; // the DONE cycle must stay idle.
	endtask

	task automatic stream_partial(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			pixel_valid <= 1'b1;
			for (int ch = 0; ch < NUM_CH; ch++) begin
				pixels[ch] <= pixel_t'($urandom);
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic read_results(input int f);
		int ch;
		int idx;
		for (int n = 0; n <= NUM_CH * WINS; n++) begin
			@(posedge clk);
			if (n < NUM_CH * WINS) begin
				rd_addr <= addr_of(n);
			end
			@(negedge clk);
			if (n > 0) begin
				ch = (n - 1) / WINS;
				idx = (n - 1) % WINS;
				check_value($sformatf("%s ch%0d win%0d", frame_name[f], ch, idx),
					longint'(window_max(ch, idx / WIN_W, idx % WIN_W)), longint'(rd_data));
			end
		end
	endtask

	initial begin
		int start_done;
		rst <= 1'b1;
		pixel_valid <= 1'b0;
		pixels <= '0;
		rd_addr <= '0;
		void'($urandom(SEED));
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// half a frame must not complete anything.
		stream_partial(IMG_W * IMG_H / 2);
		repeat (10) @(negedge clk);
		check_value("partial frame frame_done", 0, longint'(done_count));
		@(posedge clk);
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		for (int f = 0; f < N_FRAMES; f++) begin
			start_done = done_count;
			stream_frame(f);
			check_value({frame_name[f], " early frame_done"}, longint'(start_done),
				longint'(done_count));
			do begin
				@(negedge clk);
			end while (done_count == start_done);
			repeat (4) @(negedge clk);
			check_value({frame_name[f], " frame_done pulses"}, longint'(start_done + 1),
				longint'(done_count));
			read_results(f);
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
source/pool_pkg.sv
source/max_pool_2x2.sv
source/pool_write_arbiter.sv
source/pool_result_ram.sv
source/pooling_top.sv
sim/pooling_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module pooling_tb -f filelist.f \
	-o pooling_sim || { echo "build failed"; exit 1; }
output=$(./obj_dir/pooling_sim)
echo "$output"
echo "$output" | grep -qx "TESTBENCH PASSED" && echo "run ok" && exit 0
echo "run failed"
exit 1
